// ==== sys86_video_config.svh ====
`ifndef SYS86_VIDEO_CONFIG_SVH
`define SYS86_VIDEO_CONFIG_SVH

////////////////////////////////////////
// pixel clock
////////////////////////////////////////

// master clocks per pixel, 48 MHz down to 6 MHz
`define PIX_DIV 8

////////////////////////////////////////
// raster geometry, shrunk for simulation
////////////////////////////////////////

// pixels per line and visible pixels
`define H_TOTAL 48
`define H_ACTIVE 32
// hsync window, start inclusive and end exclusive
`define HSYNC_START 36
`define HSYNC_END 40

// lines per frame and visible lines
`define V_TOTAL 20
`define V_ACTIVE 16
// vsync window
`define VSYNC_START 17
`define VSYNC_END 19

// pen value of a see-through dot
`define TRANSPARENT_PEN 7
// pixel strobes from dot sample to color out
`define PIPE_DEPTH 3

`endif

// ==== sys86_video_pkg.sv ====
`include "sys86_video_config.svh"

package sys86_video_pkg;

	////////////////////////////////////////
	// pixel data
	////////////////////////////////////////

	// color index of one dot
	// low 3 bits hold the pen
	typedef logic [7:0] color_index_t;

	// one native color gun, 4 bits
	typedef logic [3:0] component_t;

	// palette word
	// red in [11:8], green in [7:4], blue in [3:0]
	typedef logic [11:0] rgb444_t;

	////////////////////////////////////////
	// raster position
	////////////////////////////////////////

	// sized from the totals so a bigger raster still fits
	typedef logic [$clog2(`H_TOTAL)-1:0] hpos_t;
	typedef logic [$clog2(`V_TOTAL)-1:0] vpos_t;

endpackage

// ==== raster_timing.sv ====
`timescale 1ns/1ps
`include "sys86_video_config.svh"

module raster_timing (
	input  logic                   clk,
	input  logic                   rst_n,
	output logic                   pix_en,
	output sys86_video_pkg::hpos_t hpos,
	output sys86_video_pkg::vpos_t vpos,
	output logic                   hblank_n,
	output logic                   vblank_n,
	output logic                   hsync_n,
	output logic                   vsync_n
);
	import sys86_video_pkg::*;

	localparam int DIV_W = $clog2(`PIX_DIV);
	localparam logic [DIV_W-1:0] DIV_LAST = DIV_W'(`PIX_DIV - 1);

	logic [DIV_W-1:0] div_cnt;
	hpos_t h_next;
	vpos_t v_next;

	////////////////////////////////////////
	// pixel strobe divider
	////////////////////////////////////////

	// strobe is registered off the wrap, one clock late
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			div_cnt <= '0;
			pix_en <= 1'b0;
		end else begin
			pix_en <= (div_cnt == DIV_LAST);
			if (div_cnt == DIV_LAST) begin
				div_cnt <= '0;
			end else begin
				div_cnt <= div_cnt + 1'b1;
			end
		end
	end

	////////////////////////////////////////
	// raster counters
	////////////////////////////////////////

	// next position, vertical steps on line wrap
	always_comb begin
		h_next = hpos + 1'b1;
		v_next = vpos;
		if (hpos == hpos_t'(`H_TOTAL - 1)) begin
			h_next = '0;
			if (vpos == vpos_t'(`V_TOTAL - 1)) begin
				v_next = '0;
			end else begin
				v_next = vpos + 1'b1;
			end
		end
	end

	// reset parks on the last dot so the first strobe lands on 0,0
	// levels come from the next position to stay in step with it
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			hpos <= hpos_t'(`H_TOTAL - 1);
			vpos <= vpos_t'(`V_TOTAL - 1);
			hblank_n <= 1'b0;
			vblank_n <= 1'b0;
			hsync_n <= 1'b1;
			vsync_n <= 1'b1;
		end else if (pix_en) begin
			hpos <= h_next;
			vpos <= v_next;
			hblank_n <= (h_next < `H_ACTIVE);
			vblank_n <= (v_next < `V_ACTIVE);
			hsync_n <= !((h_next >= `HSYNC_START) && (h_next < `HSYNC_END));
			vsync_n <= !((v_next >= `VSYNC_START) && (v_next < `VSYNC_END));
		end
	end

	// strobe is a single clock wide
	a_pix_en_single: assert property (@(posedge clk) disable iff (!rst_n)
		pix_en |=> !pix_en);

	// horizontal count never runs past the line
	a_hpos_range: assert property (@(posedge clk) disable iff (!rst_n)
		hpos < `H_TOTAL);

endmodule

// ==== layer_priority.sv ====
`timescale 1ns/1ps
`include "sys86_video_config.svh"

module layer_priority (
	input  logic                          clk,
	input  logic                          rst_n,
	input  logic                          pix_en,
	input  sys86_video_pkg::color_index_t fg_dot,
	input  sys86_video_pkg::color_index_t bg_dot,
	input  logic                          layer_swap,
	input  logic                          back_color_we,
	input  sys86_video_pkg::color_index_t back_color,
	input  logic                          hblank_n,
	input  logic                          vblank_n,
	input  logic                          hsync_n,
	input  logic                          vsync_n,
	output sys86_video_pkg::color_index_t mix_index,
	output logic                          hblank_d_n,
	output logic                          vblank_d_n,
	output logic                          hsync_d_n,
	output logic                          vsync_d_n
);
	import sys86_video_pkg::*;

	localparam logic [2:0] PEN_CLEAR = 3'(`TRANSPARENT_PEN);

	color_index_t back_latch;
	color_index_t top_dot;
	color_index_t low_dot;
	color_index_t sel_index;

	// back color latch, loads on any clock
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			back_latch <= '0;
		end else if (back_color_we) begin
			back_latch <= back_color;
		end
	end

	// swap puts the background on top
	assign top_dot = layer_swap ? bg_dot : fg_dot;
	assign low_dot = layer_swap ? fg_dot : bg_dot;

	// see-through pens fall to the next layer down
	always_comb begin
		if (top_dot[2:0] != PEN_CLEAR) begin
			sel_index = top_dot;
		end else if (low_dot[2:0] != PEN_CLEAR) begin
			sel_index = low_dot;
		end else begin
			sel_index = back_latch;
		end
	end

	////////////////////////////////////////
	// first pipeline register
	////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			mix_index <= '0;
			hblank_d_n <= 1'b0;
			vblank_d_n <= 1'b0;
			hsync_d_n <= 1'b1;
			vsync_d_n <= 1'b1;
		end else if (pix_en) begin
			mix_index <= sel_index;
			hblank_d_n <= hblank_n;
			vblank_d_n <= vblank_n;
			hsync_d_n <= hsync_n;
			vsync_d_n <= vsync_n;
		end
	end

	// a clear pen only gets out as the back color of that sample
	a_clear_is_back: assert property (@(posedge clk) disable iff (!rst_n)
		$past(pix_en) && (mix_index[2:0] == PEN_CLEAR) |-> mix_index == $past(back_latch));

endmodule

// ==== palette_lookup.sv ====
`timescale 1ns/1ps

module palette_lookup (
	input  logic                          clk,
	input  logic                          rst_n,
	input  logic                          pix_en,
	input  sys86_video_pkg::color_index_t mix_index,
	input  logic                          pal_we,
	input  sys86_video_pkg::color_index_t pal_addr,
	input  sys86_video_pkg::rgb444_t      pal_data,
	input  logic                          hblank_d_n,
	input  logic                          vblank_d_n,
	input  logic                          hsync_d_n,
	input  logic                          vsync_d_n,
	output sys86_video_pkg::rgb444_t      pal_rgb,
	output logic                          hblank_dd_n,
	output logic                          vblank_dd_n,
	output logic                          hsync_dd_n,
	output logic                          vsync_dd_n
);
	import sys86_video_pkg::*;

	localparam int PAL_DEPTH = 2 ** $bits(color_index_t);

	// one word per color index
	rgb444_t pal_ram [PAL_DEPTH];

	////////////////////////////////////////
	// host write port
	////////////////////////////////////////

	// single clock strobe, contents undefined until loaded
	always_ff @(posedge clk) begin
		if (pal_we) begin
			pal_ram[pal_addr] <= pal_data;
		end
	end

	////////////////////////////////////////
	// registered read
	////////////////////////////////////////

	// same clock as a write to that address sees the old word
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			pal_rgb <= '0;
			hblank_dd_n <= 1'b0;
			vblank_dd_n <= 1'b0;
			hsync_dd_n <= 1'b1;
			vsync_dd_n <= 1'b1;
		end else if (pix_en) begin
			pal_rgb <= pal_ram[mix_index];
			hblank_dd_n <= hblank_d_n;
			vblank_dd_n <= vblank_d_n;
			hsync_dd_n <= hsync_d_n;
			vsync_dd_n <= vsync_d_n;
		end
	end

endmodule

// ==== video_output.sv ====
`timescale 1ns/1ps

module video_output (
	input  logic                        clk,
	input  logic                        rst_n,
	input  logic                        pix_en,
	input  sys86_video_pkg::rgb444_t    pal_rgb,
	input  logic                        hblank_n,
	input  logic                        vblank_n,
	input  logic                        hsync_n,
	input  logic                        vsync_n,
	output sys86_video_pkg::component_t conn_j2_red,
	output sys86_video_pkg::component_t conn_j2_green,
	output sys86_video_pkg::component_t conn_j2_blue,
	output logic                        conn_j2_sync,
	output logic [7:0]                  vid_red,
	output logic [7:0]                  vid_green,
	output logic [7:0]                  vid_blue,
	output logic                        vid_hsync_n,
	output logic                        vid_vsync_n,
	output logic                        vid_hblank_n,
	output logic                        vid_vblank_n,
	output logic                        vid_pix
);
	import sys86_video_pkg::*;

	logic       blank;
	component_t red_m;
	component_t green_m;
	component_t blue_m;

	// either blank kills the guns
	assign blank = !(hblank_n && vblank_n);
	assign red_m = blank ? '0 : pal_rgb[11:8];
	assign green_m = blank ? '0 : pal_rgb[7:4];
	assign blue_m = blank ? '0 : pal_rgb[3:0];

	////////////////////////////////////////
	// output register
	////////////////////////////////////////

	// composite sync is low while either sync is low
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			conn_j2_red <= '0;
			conn_j2_green <= '0;
			conn_j2_blue <= '0;
			conn_j2_sync <= 1'b1;
			vid_hsync_n <= 1'b1;
			vid_vsync_n <= 1'b1;
			vid_hblank_n <= 1'b0;
			vid_vblank_n <= 1'b0;
		end else if (pix_en) begin
			conn_j2_red <= red_m;
			conn_j2_green <= green_m;
			conn_j2_blue <= blue_m;
			conn_j2_sync <= hsync_n & vsync_n;
			vid_hsync_n <= hsync_n;
			vid_vsync_n <= vsync_n;
			vid_hblank_n <= hblank_n;
			vid_vblank_n <= vblank_n;
		end
	end

	// nibble repeated so full scale maps to 8'hff
	assign vid_red = {conn_j2_red, conn_j2_red};
	assign vid_green = {conn_j2_green, conn_j2_green};
	assign vid_blue = {conn_j2_blue, conn_j2_blue};

	// pixel strobe for the capture side
	assign vid_pix = pix_en;

	// blanked output carries no color
	a_blank_black: assert property (@(posedge clk) disable iff (!rst_n)
		!(vid_hblank_n && vid_vblank_n) |-> (vid_red | vid_green | vid_blue) == 8'h00);

endmodule

// ==== sys86_video.sv ====
`timescale 1ns/1ps

module sys86_video (
	input  logic                          clk,
	input  logic                          rst_n,
	input  sys86_video_pkg::color_index_t fg_dot,
	input  sys86_video_pkg::color_index_t bg_dot,
	input  logic                          layer_swap,
	input  logic                          back_color_we,
	input  sys86_video_pkg::color_index_t back_color,
	input  logic                          pal_we,
	input  sys86_video_pkg::color_index_t pal_addr,
	input  sys86_video_pkg::rgb444_t      pal_data,
	output sys86_video_pkg::component_t   conn_j2_red,
	output sys86_video_pkg::component_t   conn_j2_green,
	output sys86_video_pkg::component_t   conn_j2_blue,
	output logic                          conn_j2_sync,
	output logic [7:0]                    vid_red,
	output logic [7:0]                    vid_green,
	output logic [7:0]                    vid_blue,
	output logic                          vid_hsync_n,
	output logic                          vid_vsync_n,
	output logic                          vid_hblank_n,
	output logic                          vid_vblank_n,
	output logic                          vid_pix
);
	import sys86_video_pkg::*;

	logic pix_en;
	// raster levels, one set per pipeline stage
	logic hblank_n, vblank_n, hsync_n, vsync_n;
	logic hblank_d_n, vblank_d_n, hsync_d_n, vsync_d_n;
	logic hblank_dd_n, vblank_dd_n, hsync_dd_n, vsync_dd_n;
	color_index_t mix_index;
	rgb444_t pal_rgb;

	////////////////////////////////////////
	// video pipeline
	////////////////////////////////////////

	// position taps left open, reachable as u_raster.hpos and u_raster.vpos
	raster_timing u_raster (
		.clk(clk), .rst_n(rst_n), .pix_en(pix_en), .hpos(), .vpos(),
		.hblank_n(hblank_n), .vblank_n(vblank_n), .hsync_n(hsync_n), .vsync_n(vsync_n)
	);

	layer_priority u_priority (
		.clk(clk), .rst_n(rst_n), .pix_en(pix_en),
		.fg_dot(fg_dot), .bg_dot(bg_dot), .layer_swap(layer_swap),
		.back_color_we(back_color_we), .back_color(back_color),
		.hblank_n(hblank_n), .vblank_n(vblank_n), .hsync_n(hsync_n), .vsync_n(vsync_n),
		.mix_index(mix_index),
		.hblank_d_n(hblank_d_n), .vblank_d_n(vblank_d_n),
		.hsync_d_n(hsync_d_n), .vsync_d_n(vsync_d_n)
	);

	palette_lookup u_palette (
		.clk(clk), .rst_n(rst_n), .pix_en(pix_en), .mix_index(mix_index),
		.pal_we(pal_we), .pal_addr(pal_addr), .pal_data(pal_data),
		.hblank_d_n(hblank_d_n), .vblank_d_n(vblank_d_n),
		.hsync_d_n(hsync_d_n), .vsync_d_n(vsync_d_n),
		.pal_rgb(pal_rgb),
		.hblank_dd_n(hblank_dd_n), .vblank_dd_n(vblank_dd_n),
		.hsync_dd_n(hsync_dd_n), .vsync_dd_n(vsync_dd_n)
	);

	video_output u_output (
		.clk(clk), .rst_n(rst_n), .pix_en(pix_en), .pal_rgb(pal_rgb),
		.hblank_n(hblank_dd_n), .vblank_n(vblank_dd_n),
		.hsync_n(hsync_dd_n), .vsync_n(vsync_dd_n),
		.conn_j2_red(conn_j2_red), .conn_j2_green(conn_j2_green),
		.conn_j2_blue(conn_j2_blue), .conn_j2_sync(conn_j2_sync),
		.vid_red(vid_red), .vid_green(vid_green), .vid_blue(vid_blue),
		.vid_hsync_n(vid_hsync_n), .vid_vsync_n(vid_vsync_n),
		.vid_hblank_n(vid_hblank_n), .vid_vblank_n(vid_vblank_n),
		.vid_pix(vid_pix)
	);

endmodule

// ==== tb_sys86_video.sv ====
`timescale 1ns/1ps
`include "sys86_video_config.svh"

module tb_sys86_video;
	import sys86_video_pkg::*;

	localparam int CLK_PERIOD = 4;
	localparam int N_ENTRIES = 10;
	localparam int FRAME_STROBES = `H_TOTAL * `V_TOTAL;
	// a few frames of slack over the table for boot, random frame and palette rewrite
	localparam int TIMEOUT_CYCLES = (N_ENTRIES + 4) * FRAME_STROBES * `PIX_DIV;
	localparam logic [15:0] LFSR_SEED = 16'd50919;

	logic clk;
	logic rst_n;
	color_index_t fg_dot;
	color_index_t bg_dot;
	logic layer_swap;
	logic back_color_we;
	color_index_t back_color;
	logic pal_we;
	color_index_t pal_addr;
	rgb444_t pal_data;
	component_t conn_j2_red;
	component_t conn_j2_green;
	component_t conn_j2_blue;
	logic conn_j2_sync;
	logic [7:0] vid_red;
	logic [7:0] vid_green;
	logic [7:0] vid_blue;
	logic vid_hsync_n;
	logic vid_vsync_n;
	logic vid_hblank_n;
	logic vid_vblank_n;
	logic vid_pix;

	////////////////////////////////////////
	// stimulus table with one entry per frame
	////////////////////////////////////////

	// pen 7 in the low bits marks a clear dot
	string tbl_name [N_ENTRIES] = '{"fg_over_bg", "fg_clear", "bg_clear", "both_clear",
		"swap_bg_over_fg", "swap_bg_clear", "swap_fg_clear", "swap_both_clear",
		"back_color", "swap_back_color"};
	color_index_t tbl_fg [N_ENTRIES] = '{8'h21, 8'h27, 8'h21, 8'h27, 8'h21,
		8'h21, 8'h27, 8'h27, 8'h27, 8'h6f};
	color_index_t tbl_bg [N_ENTRIES] = '{8'h4a, 8'h4a, 8'h4f, 8'h4f, 8'h4a,
		8'h4f, 8'h4a, 8'h4f, 8'h4f, 8'h8f};
	// bit i belongs to entry i
	logic [N_ENTRIES-1:0] tbl_swap = 10'b10_1111_0000;
	logic [N_ENTRIES-1:0] tbl_back_we = 10'b11_0000_0000;
	color_index_t tbl_back [N_ENTRIES] = '{8'h00, 8'h00, 8'h00, 8'h00, 8'h00,
		8'h00, 8'h00, 8'h00, 8'h93, 8'hc5};
	color_index_t tbl_exp [N_ENTRIES] = '{8'h21, 8'h4a, 8'h21, 8'h00, 8'h4a,
		8'h21, 8'h4a, 8'h00, 8'h93, 8'hc5};

	// reference state
	rgb444_t model_pal [256];
	color_index_t model_back;
	// expected index per sample in flight
	// -1 marks a sample taken before the palette was loaded
	int exp_q [$];
	logic [15:0] lfsr;
	string cur_name;
	color_index_t cur_fg;
	color_index_t cur_bg;
	logic cur_swap;
	int cur_exp;
	bit random_mode;
	bit pal_loaded;
	bit seen_pix;
	int release_ticks;
	int strobe_cnt;
	int color_cnt;
	int cycle_cnt = 0;
	// raster edge times in strobe counts
	int hs_fall;
	int hb_rise;
	int vs_fall;
	int hs_fall_cnt;
	int vs_fall_cnt;
	logic prev_hs;
	logic prev_hb;
	logic prev_vs;

	sys86_video DUT (
		.clk(clk), .rst_n(rst_n), .fg_dot(fg_dot), .bg_dot(bg_dot),
		.layer_swap(layer_swap), .back_color_we(back_color_we), .back_color(back_color),
		.pal_we(pal_we), .pal_addr(pal_addr), .pal_data(pal_data),
		.conn_j2_red(conn_j2_red), .conn_j2_green(conn_j2_green),
		.conn_j2_blue(conn_j2_blue), .conn_j2_sync(conn_j2_sync),
		.vid_red(vid_red), .vid_green(vid_green), .vid_blue(vid_blue),
		.vid_hsync_n(vid_hsync_n), .vid_vsync_n(vid_vsync_n),
		.vid_hblank_n(vid_hblank_n), .vid_vblank_n(vid_vblank_n), .vid_pix(vid_pix)
	);

	always #(CLK_PERIOD / 2) clk = ~clk;

	always @(posedge clk) begin
		cycle_cnt++;
		if (cycle_cnt >= TIMEOUT_CYCLES) begin
			$display("run timed out after %0d clocks without finishing", cycle_cnt);
			abort_run();
		end
	end

	////////////////////////////////////////
	// reference model
	////////////////////////////////////////

	// top layer, then lower layer, then back color
	function automatic color_index_t expected_index(input color_index_t fg,
		input color_index_t bg, input logic swap, input color_index_t back);
		color_index_t top;
		color_index_t low;
		top = swap ? bg : fg;
		low = swap ? fg : bg;
		if (top[2:0] != 3'(`TRANSPARENT_PEN)) begin
			return top;
		end else if (low[2:0] != 3'(`TRANSPARENT_PEN)) begin
			return low;
		end
		return back;
	endfunction

	// boot palette word where every address bit shows up
	function automatic rgb444_t fill_word(input color_index_t addr);
		return {addr[3:0], addr[7:4], addr[3:0] ^ addr[7:4] ^ 4'h5};
	endfunction

	// galois form with taps 16 14 13 and 11
	function automatic logic [15:0] lfsr_step(input logic [15:0] state);
		logic [15:0] next;
		next = state >> 1;
		if (state[0]) begin
			next = next ^ 16'hb400;
		end
		return next;
	endfunction

	task automatic draw_bits(input int n, output logic [15:0] value);
		int b;
		value = '0;
		for (b = 0; b < n; b++) begin
			value = {value[14:0], lfsr[0]};
			lfsr = lfsr_step(lfsr);
		end
	endtask

	////////////////////////////////////////
	// checking
	////////////////////////////////////////

	task automatic abort_run();
		$display("Result: FAILED");
		$fatal(1, "stopping at the first failure");
	endtask

	task automatic check_value(input string what, input logic [31:0] expected,
		input logic [31:0] actual);
		if (actual !== expected) begin
			$display("Error: %s %s expected %0h actual %0h", cur_name, what, expected, actual);
			abort_run();
		end
	endtask

	task automatic check_reset_state();
		check_value("reset hsync", 1, vid_hsync_n);
		check_value("reset vsync", 1, vid_vsync_n);
		check_value("reset composite sync", 1, conn_j2_sync);
		check_value("reset hblank", 0, vid_hblank_n);
		check_value("reset vblank", 0, vid_vblank_n);
		check_value("reset vid color", 0, {vid_red, vid_green, vid_blue});
		check_value("reset j2 color", 0, {conn_j2_red, conn_j2_green, conn_j2_blue});
	endtask

	// edge spacing measured in output strobes
	task automatic check_raster();
		int s;
		int p;
		logic exp_hs;
		logic exp_vs;
		s = strobe_cnt;
		// the raster register adds one strobe to the dot pipeline
		p = s - `PIPE_DEPTH - 1;
		exp_hs = 1'b1;
		exp_vs = 1'b1;
		if (p >= 0) begin
			exp_hs = !((p % `H_TOTAL >= `HSYNC_START) && (p % `H_TOTAL < `HSYNC_END));
			exp_vs = !((p / `H_TOTAL % `V_TOTAL >= `VSYNC_START)
				&& (p / `H_TOTAL % `V_TOTAL < `VSYNC_END));
		end
		check_value("hsync level", exp_hs, vid_hsync_n);
		check_value("vsync level", exp_vs, vid_vsync_n);
		check_value("composite sync", exp_hs & exp_vs, conn_j2_sync);
		if (prev_hs && !vid_hsync_n) begin
			if (hs_fall >= 0) begin
				check_value("hsync period", `H_TOTAL, s - hs_fall);
			end
			hs_fall = s;
			hs_fall_cnt++;
		end
		if (!prev_hs && vid_hsync_n && hs_fall >= 0) begin
			check_value("hsync width", `HSYNC_END - `HSYNC_START, s - hs_fall);
		end
		if (!prev_hb && vid_hblank_n) begin
			hb_rise = s;
		end
		if (prev_hb && !vid_hblank_n && hb_rise >= 0) begin
			check_value("active pixels per line", `H_ACTIVE, s - hb_rise);
		end
		if (prev_vs && !vid_vsync_n) begin
			if (vs_fall >= 0) begin
				check_value("vsync period", FRAME_STROBES, s - vs_fall);
			end
			vs_fall = s;
			vs_fall_cnt++;
		end
		prev_hs = vid_hsync_n;
		prev_hb = vid_hblank_n;
		prev_vs = vid_vsync_n;
	endtask

	// oldest sample in flight is the one on the outputs now
	task automatic check_color();
		int idx;
		rgb444_t word;
		if (exp_q.size() == `PIPE_DEPTH) begin
			idx = exp_q.pop_front();
			if (!(vid_hblank_n && vid_vblank_n)) begin
				check_value("blanked vid color", 0, {vid_red, vid_green, vid_blue});
				check_value("blanked j2 color", 0, {conn_j2_red, conn_j2_green, conn_j2_blue});
			end else if (idx >= 0) begin
				word = model_pal[idx];
				check_value("j2 rgb", word, {conn_j2_red, conn_j2_green, conn_j2_blue});
				check_value("vid rgb", {{2{word[11:8]}}, {2{word[7:4]}}, {2{word[3:0]}}},
					{vid_red, vid_green, vid_blue});
				color_cnt++;
			end
		end
	endtask

	////////////////////////////////////////
	// stimulus
	////////////////////////////////////////

	task automatic pick_random_dots();
		logic [15:0] bits;
		draw_bits(8, bits);
		cur_fg = bits[7:0];
		draw_bits(8, bits);
		cur_bg = bits[7:0];
		draw_bits(1, bits);
		cur_swap = bits[0];
		cur_exp = expected_index(cur_fg, cur_bg, cur_swap, model_back);
	endtask

	// one falling edge where strobes drop and dots go out on each pixel
	task automatic tick();
		@(negedge clk);
		back_color_we = 1'b0;
		pal_we = 1'b0;
		if (rst_n) begin
			release_ticks++;
		end
		if (!seen_pix) begin
			check_reset_state();
		end
		if (vid_pix) begin
			if (!seen_pix) begin
				check_value("first strobe delay", `PIX_DIV, release_ticks);
			end
			seen_pix = 1'b1;
			check_raster();
			check_color();
			if (random_mode) begin
				pick_random_dots();
			end
			fg_dot = cur_fg;
			bg_dot = cur_bg;
			layer_swap = cur_swap;
			exp_q.push_back(pal_loaded ? cur_exp : -1);
			strobe_cnt++;
		end
	endtask

	task automatic run_strobes(input int n);
		int seen;
		seen = 0;
		while (seen < n) begin
			tick();
			if (vid_pix) begin
				seen++;
			end
		end
	endtask

	task automatic write_palette(input color_index_t addr, input rgb444_t word);
		tick();
		pal_we = 1'b1;
		pal_addr = addr;
		pal_data = word;
		model_pal[addr] = word;
	endtask

	// lands between strobes so no sample sees a half-updated latch
	task automatic write_back_color(input color_index_t value);
		tick();
		while (vid_pix) begin
			tick();
		end
		back_color_we = 1'b1;
		back_color = value;
		model_back = value;
	endtask

	// start of the output vertical blank
	task automatic wait_vblank();
		tick();
		while (!(vid_pix && vid_vblank_n)) begin
			tick();
		end
		while (!(vid_pix && !vid_vblank_n)) begin
			tick();
		end
	endtask

	task automatic apply_entry(input int i, input string name);
		if (tbl_back_we[i]) begin
			write_back_color(tbl_back[i]);
		end
		cur_name = name;
		cur_fg = tbl_fg[i];
		cur_bg = tbl_bg[i];
		cur_swap = tbl_swap[i];
		cur_exp = tbl_exp[i];
		run_strobes(FRAME_STROBES);
	endtask

	initial begin
		int i;
		int a;
		logic [15:0] bits;
		clk = 1'b0;
		rst_n = 1'b0;
		fg_dot = '0;
		bg_dot = '0;
		layer_swap = 1'b0;
		back_color_we = 1'b0;
		back_color = '0;
		pal_we = 1'b0;
		pal_addr = '0;
		pal_data = '0;
		lfsr = LFSR_SEED;
		model_back = '0;
		cur_name = "reset";
		cur_fg = '0;
		cur_bg = '0;
		cur_swap = 1'b0;
		cur_exp = 0;
		random_mode = 1'b0;
		pal_loaded = 1'b0;
		seen_pix = 1'b0;
		release_ticks = 0;
		strobe_cnt = 0;
		color_cnt = 0;
		hs_fall = -1;
		hb_rise = -1;
		vs_fall = -1;
		hs_fall_cnt = 0;
		vs_fall_cnt = 0;
		prev_hs = 1'b1;
		prev_hb = 1'b0;
		prev_vs = 1'b1;

		repeat (4) tick();
		rst_n = 1'b1;

		// palette ram has no reset
		cur_name = "palette_boot";
		for (a = 0; a < 256; a++) begin
			write_palette(color_index_t'(a), fill_word(color_index_t'(a)));
		end
		pal_loaded = 1'b1;

		for (i = 0; i < N_ENTRIES; i++) begin
			apply_entry(i, tbl_name[i]);
		end

		cur_name = "random_dots";
		random_mode = 1'b1;
		run_strobes(FRAME_STROBES);
		random_mode = 1'b0;

		// 256 writes fit well inside the blanked lines
		cur_name = "palette_rewrite";
		wait_vblank();
		for (a = 0; a < 256; a++) begin
			draw_bits(12, bits);
			write_palette(color_index_t'(a), bits[11:0]);
		end
		apply_entry(0, "fg_over_bg_new_palette");
		run_strobes(`PIPE_DEPTH);

		if (hs_fall_cnt >= `V_TOTAL && vs_fall_cnt >= 2 && color_cnt > 0) begin
			$display("Result: PASSED");
			$finish;
		end else begin
			$display("sync edges or colored pixels never showed up on the outputs");
			abort_run();
		end
	end

endmodule

// ==== sources.f ====
+incdir+.
sys86_video_pkg.sv
raster_timing.sv
layer_priority.sv
palette_lookup.sv
video_output.sv
sys86_video.sv
tb_sys86_video.sv

// ==== Makefile ====
.PHONY: help test clean

help:
	@echo "make test   build with Verilator, run the testbench, fail unless it passes"
	@echo "make clean  remove the build folder"
	@echo "make help   list these targets"

build/Vtb_sys86_video: sources.f $(wildcard *.sv *.svh)
	verilator --binary --assert -Wno-fatal -f sources.f --top-module tb_sys86_video -Mdir build

test: build/Vtb_sys86_video
	@out="$$(./build/Vtb_sys86_video 2>&1)"; echo "$$out"; \
	echo "$$out" | grep -q "Result: PASSED"

clean:
	rm -rf build
